/* sim.f */
+incdir+common
common/idu_pkg.sv
common/idu_cand_if.sv
idu/idu_mux_key.sv
idu/idu_funct7.sv
idu/idu_funct3_sel.sv
idu/idu_top.sv
tb/idu_asserts.sv
tb/idu_tb.sv

/* Bender.yml */
package:
  name: idu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/idu_pkg.sv
      - common/idu_cand_if.sv
      - idu/idu_mux_key.sv
      - idu/idu_funct7.sv
      - idu/idu_funct3_sel.sv
      - idu/idu_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - tb/idu_asserts.sv
      - tb/idu_tb.sv

/* tb/idu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "idu_defs.svh"

module idu_tb;

    localparam int ACK_WAIT = 10;

    logic               clk;
    logic               arst_n;
    idu_pkg::inst_t     inst;
    logic               inst_req;
    logic               inst_ack;
    idu_pkg::inst_num_t inst_num;

    integer         seed = 32'h4888;
    idu_pkg::inst_t tests[$];
    int             cycle_count = 0;
    int             timeout_limit = 0;

    idu_top i_idu_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .inst    (inst),
        .inst_req(inst_req),
        .inst_ack(inst_ack),
        .inst_num(inst_num)
    );

    bind idu_top idu_asserts i_idu_asserts (
        .clk     (clk),
        .arst_n  (arst_n),
        .inst_req(inst_req),
        .inst_ack(inst_ack),
        .inst_num(inst_num),
        .state   (state)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // Register fields and the rest of the word are random
    function automatic idu_pkg::inst_t make_word(input idu_pkg::funct7_t f7,
                                                 input idu_pkg::funct3_t f3,
                                                 input idu_pkg::opcode_t opc);
        logic [31:0] r;
        r = rand_word();
        return {f7, r[24:15], f3, r[11:7], opc};
    endfunction

    // Reference decode written from the RV32I field rules
    function automatic idu_pkg::inst_num_t expected_num(input idu_pkg::inst_t w);
        idu_pkg::funct7_t   f7;
        idu_pkg::funct3_t   f3;
        idu_pkg::inst_num_t num;
        f7 = w[31:25];
        f3 = w[14:12];
        num = `INST_NUM_WIDTH'd`inv;
        if (w[6:0] == 7'b0110011) begin
            if (f7 == 7'b0000000) begin
                case (f3)
                    3'b000: num = `INST_NUM_WIDTH'd`add;
                    3'b001: num = `INST_NUM_WIDTH'd`sll;
                    3'b010: num = `INST_NUM_WIDTH'd`slt;
                    3'b011: num = `INST_NUM_WIDTH'd`sltu;
                    3'b100: num = `INST_NUM_WIDTH'd`ixor;
                    3'b101: num = `INST_NUM_WIDTH'd`srl;
                    3'b110: num = `INST_NUM_WIDTH'd`ior;
                    default: num = `INST_NUM_WIDTH'd`iand;
                endcase
            end else if (f7 == 7'b0100000 && f3 == 3'b000) begin
                num = `INST_NUM_WIDTH'd`sub;
            end else if (f7 == 7'b0100000 && f3 == 3'b101) begin
                num = `INST_NUM_WIDTH'd`sra;
            end
        end else if (w[6:0] == 7'b0010011) begin
            case (f3)
                3'b000: num = `INST_NUM_WIDTH'd`addi;
                3'b010: num = `INST_NUM_WIDTH'd`slti;
                3'b011: num = `INST_NUM_WIDTH'd`sltiu;
                3'b100: num = `INST_NUM_WIDTH'd`xori;
                3'b110: num = `INST_NUM_WIDTH'd`ori;
                3'b111: num = `INST_NUM_WIDTH'd`andi;
                3'b001: begin
                    if (f7 == 7'b0000000) num = `INST_NUM_WIDTH'd`slli;
                end
                default: begin
                    if (f7 == 7'b0000000) num = `INST_NUM_WIDTH'd`srli;
                    else if (f7 == 7'b0100000) num = `INST_NUM_WIDTH'd`srai;
                end
            endcase
        end else if (w == 32'h00100073) begin
            num = `INST_NUM_WIDTH'd`ebreak;
        end
        return num;
    endfunction

    task automatic build_tests();
        idu_pkg::funct3_t imm_f3[6] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
        for (int f3 = 0; f3 < 8; f3++) begin
            tests.push_back(make_word(7'b0000000, 3'(f3), `OPC_OP));
        end
        tests.push_back(make_word(7'b0100000, 3'b000, `OPC_OP));
        tests.push_back(make_word(7'b0100000, 3'b101, `OPC_OP));
        // Unlisted funct7 values
        tests.push_back(make_word(7'b0000001, 3'b000, `OPC_OP));
        tests.push_back(make_word(7'b0100000, 3'b001, `OPC_OP));
        tests.push_back(make_word(7'b0100000, 3'b111, `OPC_OP));
        tests.push_back(make_word(7'b1111111, 3'b101, `OPC_OP));
        tests.push_back(make_word(7'b0000000, 3'b001, `OPC_OP_IMM));
        tests.push_back(make_word(7'b0000000, 3'b101, `OPC_OP_IMM));
        tests.push_back(make_word(7'b0100000, 3'b101, `OPC_OP_IMM));
        tests.push_back(make_word(7'b0100000, 3'b001, `OPC_OP_IMM));
        tests.push_back(make_word(7'b0000001, 3'b101, `OPC_OP_IMM));
        tests.push_back(make_word(7'b1100000, 3'b101, `OPC_OP_IMM));
        // The funct7 slot is just immediate bits here
        foreach (imm_f3[i]) begin
            tests.push_back(make_word(7'(rand_word()), imm_f3[i], `OPC_OP_IMM));
        end
        tests.push_back(32'h00100073);
        tests.push_back(32'h00000073);
        tests.push_back(32'h001000f3);
        tests.push_back(32'h0000a083);
        tests.push_back(32'h0080006f);
        repeat (8) tests.push_back(make_word(7'(rand_word()), 3'(rand_word()), `OPC_OP));
        repeat (8) tests.push_back(make_word(7'(rand_word()), 3'(rand_word()), `OPC_OP_IMM));
        repeat (8) tests.push_back(rand_word());
    endtask

    task automatic run_transfer(input idu_pkg::inst_t word);
        idu_pkg::inst_num_t exp_num;
        int                 waited;
        int                 hold;
        int                 gap;
        exp_num = expected_num(word);
        inst = word;
        inst_req = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!inst_ack && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!inst_ack) begin
            abort_run("inst_ack did not rise after inst_req was raised");
        end
        check_num: assert (inst_num == exp_num) else begin
            abort_run($sformatf("Fail inst_num inst=0x%h expected=0x%h actual=0x%h",
                                word, exp_num, inst_num));
        end
        // The bus is free once ack is seen
        // The held result must come from the registered word
        inst = rand_word();
        // A slow source keeps req high for a few cycles after ack
        hold = rand_word() % 4;
        repeat (hold) @(negedge clk);
        inst_req = 1'b0;
        waited = 0;
        @(negedge clk);
        while (inst_ack && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (inst_ack) begin
            abort_run("inst_ack did not fall after inst_req was released");
        end
        gap = rand_word() % 4;
        repeat (gap) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            abort_run("Timeout because the req/ack handshake stalled");
        end
    end

    always @(negedge clk) begin
        if (i_idu_top.i_idu_asserts.fail_count != 0) begin
            abort_run("A bound assertion on the handshake or reset state failed");
        end
    end

    initial begin
        inst = '0;
        inst_req = 1'b0;
        arst_n = 1'b0;
        build_tests();
        timeout_limit = 40 * tests.size() + 100;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        foreach (tests[i]) begin
            run_transfer(tests[i]);
        end
        repeat (3) @(negedge clk);
        if (i_idu_top.i_idu_asserts.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run("A bound assertion failed near the end of the run");
        end
    end

endmodule

`default_nettype wire

/* tb/idu_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "idu_defs.svh"

module idu_asserts (
    input logic               clk,
    input logic               arst_n,
    input logic               inst_req,
    input logic               inst_ack,
    input idu_pkg::inst_num_t inst_num,
    input idu_pkg::hs_state_t state
);

    localparam idu_pkg::inst_num_t INV_NUM = `INST_NUM_WIDTH'd`inv;

    // Number of assertion failures so far
    int unsigned fail_count = 0;

    ack_low_in_reset: assert property (@(posedge clk) !arst_n |-> !inst_ack)
        else begin
            fail_count++;
            $error("inst_ack is high during reset");
        end

    reset_values: assert property (@(posedge clk) $rose(arst_n) |-> (inst_num == INV_NUM && !inst_ack))
        else begin
            fail_count++;
            $error("inst_num or inst_ack wrong right after reset");
        end

    // Load edge, decode edge, then ack is seen
    ack_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (state == idu_pkg::HS_IDLE && inst_req) |=> !inst_ack ##1 inst_ack)
        else begin
            fail_count++;
            $error("inst_ack did not rise two cycles after inst_req");
        end

    result_stable: assert property (@(posedge clk) disable iff (!arst_n)
        inst_ack |=> $stable(inst_num))
        else begin
            fail_count++;
            $error("inst_num changed while inst_ack was high");
        end

    ack_held: assert property (@(posedge clk) disable iff (!arst_n)
        (inst_ack && inst_req) |=> inst_ack)
        else begin
            fail_count++;
            $error("inst_ack dropped while inst_req was still high");
        end

    ack_release: assert property (@(posedge clk) disable iff (!arst_n)
        (inst_ack && !inst_req) |=> !inst_ack)
        else begin
            fail_count++;
            $error("inst_ack did not fall one cycle after inst_req dropped");
        end

endmodule

`default_nettype wire

/* idu/idu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "idu_defs.svh"

module idu_top (
    input  logic                clk,
    input  logic                arst_n,
    input  idu_pkg::inst_t      inst,
    input  logic                inst_req,
    output logic                inst_ack,
    output idu_pkg::inst_num_t  inst_num
);

    idu_pkg::hs_state_t state;
    idu_pkg::hs_state_t state_nxt;
    idu_pkg::inst_t     inst_q;
    idu_pkg::inst_num_t dec_num;

    idu_cand_if cand_if ();

    idu_funct7 i_idu_funct7 (
        .inst(inst_q),
        .cand(cand_if)
    );

    idu_funct3_sel i_idu_funct3_sel (
        .inst    (inst_q),
        .cand    (cand_if),
        .inst_num(dec_num)
    );

    // Four-phase handshake, one instruction in flight
    always_comb begin
        state_nxt = state;
        case (state)
            idu_pkg::HS_IDLE: begin
                if (inst_req) begin
                    state_nxt = idu_pkg::HS_DECODE;
                end
            end
            idu_pkg::HS_DECODE: begin
                state_nxt = idu_pkg::HS_ACK;
            end
            idu_pkg::HS_ACK: begin
                // Stay here until the source releases req
                if (!inst_req) begin
                    state_nxt = idu_pkg::HS_IDLE;
                end
            end
            default: begin
                state_nxt = idu_pkg::HS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idu_pkg::HS_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // The source keeps inst stable while req is high, so one sample is enough
    always_ff @(posedge clk) begin
        if (state == idu_pkg::HS_IDLE && inst_req) begin
            inst_q <= inst;
        end
    end

    // Result is held until the next decode, so it stays stable under ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst_num <= `INST_NUM_WIDTH'd`inv;
        end else if (state == idu_pkg::HS_DECODE) begin
            inst_num <= dec_num;
        end
    end

    assign inst_ack = (state == idu_pkg::HS_ACK);

endmodule

`default_nettype wire

/* idu/idu_funct3_sel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "idu_defs.svh"

module idu_funct3_sel (
    input  idu_pkg::inst_t      inst,
    idu_cand_if.consumer        cand,
    output idu_pkg::inst_num_t  inst_num
);

    localparam idu_pkg::inst_num_t INV_NUM = `INST_NUM_WIDTH'd`inv;

    idu_pkg::opcode_t   opcode;
    idu_pkg::funct3_t   funct3;
    idu_pkg::inst_num_t op_num;
    idu_pkg::inst_num_t op_imm_num;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    idu_mux_key #(
        .NR_KEY(`FUNCT3_NUM_MAX), .KEY_LEN(`FUNCT3_WIDTH), .DATA_LEN(`INST_NUM_WIDTH)
    ) i_op (
        .key        (funct3),
        .default_out(INV_NUM),
        .lut        ({
                    `FUNCT3_WIDTH'b000, cand.add_num,
                    `FUNCT3_WIDTH'b001, cand.sll_num,
                    `FUNCT3_WIDTH'b010, cand.slt_num,
                    `FUNCT3_WIDTH'b011, cand.sltu_num,
                    `FUNCT3_WIDTH'b100, cand.xor_num,
                    `FUNCT3_WIDTH'b101, cand.srl_num,
                    `FUNCT3_WIDTH'b110, cand.or_num,
                    `FUNCT3_WIDTH'b111, cand.and_num
        }),
        .out        (op_num)
    );

    // Only the two shifts look at funct7, the rest come straight from funct3
    idu_mux_key #(
        .NR_KEY(`FUNCT3_NUM_MAX), .KEY_LEN(`FUNCT3_WIDTH), .DATA_LEN(`INST_NUM_WIDTH)
    ) i_op_imm (
        .key        (funct3),
        .default_out(INV_NUM),
        .lut        ({
                    `FUNCT3_WIDTH'b000, `INST_NUM_WIDTH'd`addi,
                    `FUNCT3_WIDTH'b001, cand.slli_num,
                    `FUNCT3_WIDTH'b010, `INST_NUM_WIDTH'd`slti,
                    `FUNCT3_WIDTH'b011, `INST_NUM_WIDTH'd`sltiu,
                    `FUNCT3_WIDTH'b100, `INST_NUM_WIDTH'd`xori,
                    `FUNCT3_WIDTH'b101, cand.srli_num,
                    `FUNCT3_WIDTH'b110, `INST_NUM_WIDTH'd`ori,
                    `FUNCT3_WIDTH'b111, `INST_NUM_WIDTH'd`andi
        }),
        .out        (op_imm_num)
    );

    always_comb begin
        case (opcode)
            `OPC_OP:     inst_num = op_num;
            `OPC_OP_IMM: inst_num = op_imm_num;
            // The candidate already compared the full word
            `OPC_SYSTEM: inst_num = cand.ebreak_num;
            default:     inst_num = INV_NUM;
        endcase
    end

endmodule

`default_nettype wire

/* idu/idu_funct7.sv */
`timescale 1ns/1ps
`default_nettype none

`include "idu_defs.svh"

module idu_funct7 (
    input  idu_pkg::inst_t  inst,
    idu_cand_if.producer    cand
);

    localparam idu_pkg::funct7_t F7_BASE = 7'b0000000;
    localparam idu_pkg::funct7_t F7_ALT  = 7'b0100000;
    localparam idu_pkg::inst_num_t INV_NUM = `INST_NUM_WIDTH'd`inv;

    idu_pkg::funct7_t funct7;

    assign funct7 = inst[31:25];

    // Shift-immediates share the funct7 slot with the R-type groups
    idu_mux_key #(
        .NR_KEY(`SLLI_NUM_MAX), .KEY_LEN(`FUNCT7_WIDTH), .DATA_LEN(`INST_NUM_WIDTH)
    ) i_slli (
        .key        (funct7),
        .default_out(INV_NUM),
        .lut        ({F7_BASE, `INST_NUM_WIDTH'd`slli}),
        .out        (cand.slli_num)
    );

    idu_mux_key #(
        .NR_KEY(`SRLI_NUM_MAX), .KEY_LEN(`FUNCT7_WIDTH), .DATA_LEN(`INST_NUM_WIDTH)
    ) i_srli (
        .key        (funct7),
        .default_out(INV_NUM),
        .lut        ({F7_BASE, `INST_NUM_WIDTH'd`srli, F7_ALT, `INST_NUM_WIDTH'd`srai}),
        .out        (cand.srli_num)
    );

    idu_mux_key #(
        .NR_KEY(`ADD_NUM_MAX), .KEY_LEN(`FUNCT7_WIDTH), .DATA_LEN(`INST_NUM_WIDTH)
    ) i_add (
        .key        (funct7),
        .default_out(INV_NUM),
        .lut        ({F7_BASE, `INST_NUM_WIDTH'd`add, F7_ALT, `INST_NUM_WIDTH'd`sub}),
        .out        (cand.add_num)
    );

    idu_mux_key #(
        .NR_KEY(`SLL_NUM_MAX), .KEY_LEN(`FUNCT7_WIDTH), .DATA_LEN(`INST_NUM_WIDTH)
    ) i_sll (
        .key        (funct7),
        .default_out(INV_NUM),
        .lut        ({F7_BASE, `INST_NUM_WIDTH'd`sll}),
        .out        (cand.sll_num)
    );

    idu_mux_key #(
        .NR_KEY(`SLT_NUM_MAX), .KEY_LEN(`FUNCT7_WIDTH), .DATA_LEN(`INST_NUM_WIDTH)
    ) i_slt (
        .key        (funct7),
        .default_out(INV_NUM),
        .lut        ({F7_BASE, `INST_NUM_WIDTH'd`slt}),
        .out        (cand.slt_num)
    );

    idu_mux_key #(
        .NR_KEY(`SLTU_NUM_MAX), .KEY_LEN(`FUNCT7_WIDTH), .DATA_LEN(`INST_NUM_WIDTH)
    ) i_sltu (
        .key        (funct7),
        .default_out(INV_NUM),
        .lut        ({F7_BASE, `INST_NUM_WIDTH'd`sltu}),
        .out        (cand.sltu_num)
    );

    idu_mux_key #(
        .NR_KEY(`XOR_NUM_MAX), .KEY_LEN(`FUNCT7_WIDTH), .DATA_LEN(`INST_NUM_WIDTH)
    ) i_xor (
        .key        (funct7),
        .default_out(INV_NUM),
        .lut        ({F7_BASE, `INST_NUM_WIDTH'd`ixor}),
        .out        (cand.xor_num)
    );

    idu_mux_key #(
        .NR_KEY(`SRL_NUM_MAX), .KEY_LEN(`FUNCT7_WIDTH), .DATA_LEN(`INST_NUM_WIDTH)
    ) i_srl (
        .key        (funct7),
        .default_out(INV_NUM),
        .lut        ({F7_BASE, `INST_NUM_WIDTH'd`srl, F7_ALT, `INST_NUM_WIDTH'd`sra}),
        .out        (cand.srl_num)
    );

    idu_mux_key #(
        .NR_KEY(`OR_NUM_MAX), .KEY_LEN(`FUNCT7_WIDTH), .DATA_LEN(`INST_NUM_WIDTH)
    ) i_or (
        .key        (funct7),
        .default_out(INV_NUM),
        .lut        ({F7_BASE, `INST_NUM_WIDTH'd`ior}),
        .out        (cand.or_num)
    );

    idu_mux_key #(
        .NR_KEY(`AND_NUM_MAX), .KEY_LEN(`FUNCT7_WIDTH), .DATA_LEN(`INST_NUM_WIDTH)
    ) i_and (
        .key        (funct7),
        .default_out(INV_NUM),
        .lut        ({F7_BASE, `INST_NUM_WIDTH'd`iand}),
        .out        (cand.and_num)
    );

    // ECALL and the other SYSTEM words differ from EBREAK outside funct7
    assign cand.ebreak_num = (inst == `INST_EBREAK) ? `INST_NUM_WIDTH'd`ebreak : INV_NUM;

endmodule

`default_nettype wire

/* idu/idu_mux_key.sv */
`timescale 1ns/1ps
`default_nettype none

module idu_mux_key #(
    parameter int NR_KEY   = 2,
    parameter int KEY_LEN  = 1,
    parameter int DATA_LEN = 1
) (
    input  logic [KEY_LEN-1:0]                    key,
    input  logic [DATA_LEN-1:0]                   default_out,
    input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0]  lut,
    output logic [DATA_LEN-1:0]                   out
);

    localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

    // Each table entry is {key, data}, data in the low bits
    // Keys are expected to be unique, so entry order does not matter
    always_comb begin
        out = default_out;
        for (int i = 0; i < NR_KEY; i++) begin
            if (lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == key) begin
                out = lut[i*PAIR_LEN +: DATA_LEN];
            end
        end
    end

endmodule

`default_nettype wire

/* common/idu_cand_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface idu_cand_if;

    // One candidate per (opcode, funct3) group, already resolved by funct7
    idu_pkg::inst_num_t slli_num;
    idu_pkg::inst_num_t srli_num;
    idu_pkg::inst_num_t add_num;
    idu_pkg::inst_num_t sll_num;
    idu_pkg::inst_num_t slt_num;
    idu_pkg::inst_num_t sltu_num;
    idu_pkg::inst_num_t xor_num;
    idu_pkg::inst_num_t srl_num;
    idu_pkg::inst_num_t or_num;
    idu_pkg::inst_num_t and_num;
    idu_pkg::inst_num_t ebreak_num;

    modport producer (
        output slli_num, srli_num, add_num, sll_num, slt_num, sltu_num,
               xor_num, srl_num, or_num, and_num, ebreak_num
    );

    modport consumer (
        input slli_num, srli_num, add_num, sll_num, slt_num, sltu_num,
              xor_num, srl_num, or_num, and_num, ebreak_num
    );

endinterface

`default_nettype wire

/* common/idu_pkg.sv */
`default_nettype none

`include "idu_defs.svh"

package idu_pkg;

    // Raw instruction word as fetched
    typedef logic [`ISA_WIDTH-1:0] inst_t;

    // Compact code naming the decoded operation
    typedef logic [`INST_NUM_WIDTH-1:0] inst_num_t;

    // Instruction fields
    typedef logic [`FUNCT7_WIDTH-1:0] funct7_t;
    typedef logic [`FUNCT3_WIDTH-1:0] funct3_t;
    typedef logic [`OPCODE_WIDTH-1:0] opcode_t;

    // Four-phase req/ack controller
    // HS_DECODE is the single cycle in which the registered word is decoded
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_DECODE,
        HS_ACK
    } hs_state_t;

endpackage

`default_nettype wire

/* common/idu_defs.svh */
`ifndef IDU_DEFS_SVH
`define IDU_DEFS_SVH

// Field widths of the RV32I encoding
`define ISA_WIDTH       32
`define INST_NUM_WIDTH  6
`define FUNCT7_WIDTH    7
`define FUNCT3_WIDTH    3
`define OPCODE_WIDTH    7

// Instruction numbers, zero is reserved for anything not decoded
`define inv     0
`define add     1
`define sub     2
`define sll     3
`define slt     4
`define sltu    5
`define ixor    6
`define srl     7
`define sra     8
`define ior     9
`define iand    10
`define slli    11
`define srli    12
`define srai    13
`define addi    14
`define slti    15
`define sltiu   16
`define xori    17
`define ori     18
`define andi    19
`define ebreak  20

// Major opcodes handled by the stage
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_SYSTEM  7'b1110011

// EBREAK only matches the complete word
`define INST_EBREAK 32'h00100073

// Table sizes for the funct7 lookups
`define SLLI_NUM_MAX    1
`define SRLI_NUM_MAX    2
`define ADD_NUM_MAX     2
`define SLL_NUM_MAX     1
`define SLT_NUM_MAX     1
`define SLTU_NUM_MAX    1
`define XOR_NUM_MAX     1
`define SRL_NUM_MAX     2
`define OR_NUM_MAX      1
`define AND_NUM_MAX     1

// Every funct3 value has an entry in the selection tables
`define FUNCT3_NUM_MAX  8

`endif
